//--- bridge_pkg.sv
/*
 * Shared widths, depths and memory size for the AXI bridge,
 * plus the bus command, response and state enums.
 */
`default_nettype none

package bridge_pkg;

  // data path widths.
  localparam int ADDR_WIDTH      = 16;  // byte address.
  localparam int DATA_WIDTH      = 32;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int ID_WIDTH        = 4;
  localparam int LEN_WIDTH       = 4;   // axi burst length field.
  localparam int CMD_LEN_WIDTH   = 5;   // beat count, 1 to 16.
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;

  // queue depths.
  localparam int CMD_FIFO_DEPTH  = 2;
  localparam int BID_FIFO_DEPTH  = 4;
  localparam int BCNT_WIDTH      = $clog2(BID_FIFO_DEPTH + 1);
  localparam int CMD_WIDTH       = ID_WIDTH + ADDR_WIDTH + CMD_LEN_WIDTH;

  // target memory.
  localparam int MEM_WORDS       = 256;
  localparam int MEM_ADDR_WIDTH  = $clog2(MEM_WORDS);

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } bus_cmd_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic {
    RD = 1'b0,
    WR = 1'b1
  } arb_owner_e;

  typedef enum logic [1:0] {
    IDLE        = 2'b00,
    READ_BURST  = 2'b01,
    WRITE_BURST = 2'b10
  } tgt_state_e;

endpackage

`default_nettype wire

//--- sync_fifo.sv
/*
 * First-word-fall-through synchronous FIFO, WIDTH x DEPTH,
 * with a check against overflow and underflow.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  output logic             o_full,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty
);
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full  = (count == CNT_WIDTH'(DEPTH));
  assign o_empty = (count == '0);
  assign o_data  = mem[rd_ptr];  // oldest entry shows directly.

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= next_ptr(wr_ptr);
      if (i_pop) rd_ptr <= next_ptr(rd_ptr);
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or push and pop together.
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= i_data;
  end

  // the producer must honour full and the consumer must honour empty.
  a_no_overflow_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(i_push && o_full) && !(i_pop && o_empty));

endmodule

`default_nettype wire

//--- read_cmd_path.sv
/*
 * AR to read command queue, and target read beats to the R channel.
 */
`timescale 1ns/1ps
`default_nettype none

module read_cmd_path (
  input  logic                                i_clk,
  input  logic                                i_rst_n,
  input  logic                                i_arvalid,
  output logic                                o_arready,
  input  logic [bridge_pkg::ID_WIDTH-1:0]     i_arid,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0]   i_araddr,
  input  logic [bridge_pkg::LEN_WIDTH-1:0]    i_arlen,
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output logic [bridge_pkg::ID_WIDTH-1:0]     o_rid,
  output logic [bridge_pkg::DATA_WIDTH-1:0]   o_rdata,
  output bridge_pkg::axi_resp_e               o_rresp,
  output logic                                o_rlast,
  output logic                                o_cmd_valid,
  input  logic                                i_cmd_accept,
  output logic [bridge_pkg::ID_WIDTH-1:0]     o_cmd_id,
  output logic [bridge_pkg::ADDR_WIDTH-1:0]   o_cmd_addr,
  output logic [bridge_pkg::CMD_LEN_WIDTH-1:0] o_cmd_len,
  input  logic                                i_resp_valid,
  output logic                                o_resp_accept,
  input  logic [bridge_pkg::ID_WIDTH-1:0]     i_resp_id,
  input  logic [bridge_pkg::DATA_WIDTH-1:0]   i_resp_data,
  input  logic                                i_resp_last,
  input  logic                                i_resp_error
);
  logic                             cmd_full;
  logic                             cmd_empty;
  logic [bridge_pkg::CMD_WIDTH-1:0] cmd_in;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] beats;

  assign beats     = bridge_pkg::CMD_LEN_WIDTH'(i_arlen) + 1'b1;  // axlen + 1.
  assign cmd_in    = {i_arid, i_araddr[bridge_pkg::ADDR_WIDTH-1:2], 2'b00, beats};
  assign o_arready = !cmd_full;
  assign o_cmd_valid = !cmd_empty;

  sync_fifo #(
    .WIDTH (bridge_pkg::CMD_WIDTH),
    .DEPTH (bridge_pkg::CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (i_arvalid && !cmd_full),
    .i_data  (cmd_in),
    .o_full  (cmd_full),
    .i_pop   (o_cmd_valid && i_cmd_accept),
    .o_data  ({o_cmd_id, o_cmd_addr, o_cmd_len}),
    .o_empty (cmd_empty)
  );

  // R channel is a straight mapping of the target response.
  assign o_rvalid      = i_resp_valid;
  assign o_resp_accept = i_rready;
  assign o_rid         = i_resp_id;
  assign o_rdata       = i_resp_data;
  assign o_rlast       = i_resp_last;
  assign o_rresp       = i_resp_error ? bridge_pkg::SLVERR : bridge_pkg::OKAY;

endmodule

`default_nettype wire

//--- write_cmd_path.sv
/*
 * AW to write command queue, W beats forwarded to the target,
 * and B responses built from an ID FIFO and a burst counter.
 */
`timescale 1ns/1ps
`default_nettype none

module write_cmd_path (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_awvalid,
  output logic                                 o_awready,
  input  logic [bridge_pkg::ID_WIDTH-1:0]      i_awid,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_awaddr,
  input  logic [bridge_pkg::LEN_WIDTH-1:0]     i_awlen,
  input  logic                                 i_wvalid,
  output logic                                 o_wready,
  input  logic [bridge_pkg::DATA_WIDTH-1:0]    i_wdata,
  input  logic [bridge_pkg::STRB_WIDTH-1:0]    i_wstrb,
  input  logic                                 i_wlast,
  output logic                                 o_bvalid,
  input  logic                                 i_bready,
  output logic [bridge_pkg::ID_WIDTH-1:0]      o_bid,
  output bridge_pkg::axi_resp_e                o_bresp,
  output logic                                 o_cmd_valid,
  input  logic                                 i_cmd_accept,
  output logic [bridge_pkg::ID_WIDTH-1:0]      o_cmd_id,
  output logic [bridge_pkg::ADDR_WIDTH-1:0]    o_cmd_addr,
  output logic [bridge_pkg::CMD_LEN_WIDTH-1:0] o_cmd_len,
  output logic                                 o_data_valid,
  input  logic                                 i_data_accept,
  output logic [bridge_pkg::DATA_WIDTH-1:0]    o_data,
  output logic [bridge_pkg::STRB_WIDTH-1:0]    o_data_byteen,
  output logic                                 o_data_last
);
  logic                                 cmd_full;
  logic                                 cmd_empty;
  logic                                 bid_full;
  logic                                 bid_empty;
  logic                                 aw_fire;
  logic                                 burst_done;
  logic                                 b_fire;
  logic                                 cnt_room;
  logic [bridge_pkg::BCNT_WIDTH-1:0]    burst_cnt;  // finished W bursts without B.
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] beats;
  logic [bridge_pkg::CMD_WIDTH-1:0]     cmd_in;

  assign beats     = bridge_pkg::CMD_LEN_WIDTH'(i_awlen) + 1'b1;
  assign cmd_in    = {i_awid, i_awaddr[bridge_pkg::ADDR_WIDTH-1:2], 2'b00, beats};
  assign o_awready = !cmd_full && !bid_full;  // needs room in both queues.
  assign aw_fire   = i_awvalid && o_awready;
  assign o_cmd_valid = !cmd_empty;

  sync_fifo #(
    .WIDTH (bridge_pkg::CMD_WIDTH),
    .DEPTH (bridge_pkg::CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (aw_fire),
    .i_data  (cmd_in),
    .o_full  (cmd_full),
    .i_pop   (o_cmd_valid && i_cmd_accept),
    .o_data  ({o_cmd_id, o_cmd_addr, o_cmd_len}),
    .o_empty (cmd_empty)
  );

  sync_fifo #(
    .WIDTH (bridge_pkg::ID_WIDTH),
    .DEPTH (bridge_pkg::BID_FIFO_DEPTH)
  ) u_bid_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (aw_fire),
    .i_data  (i_awid),
    .o_full  (bid_full),
    .i_pop   (b_fire),
    .o_data  (o_bid),
    .o_empty (bid_empty)
  );

  // W beats go straight to the target.
  assign cnt_room      = (burst_cnt < bridge_pkg::BCNT_WIDTH'(bridge_pkg::BID_FIFO_DEPTH));
  assign o_wready      = cnt_room && i_data_accept;
  assign o_data_valid  = cnt_room && i_wvalid;
  assign o_data        = i_wdata;
  assign o_data_byteen = i_wstrb;
  assign o_data_last   = i_wlast;

  assign burst_done = i_wvalid && o_wready && i_wlast;
  assign o_bvalid   = (burst_cnt != '0) && !bid_empty;
  assign b_fire     = o_bvalid && i_bready;
  assign o_bresp    = bridge_pkg::OKAY;  // write errors are not reported.

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      burst_cnt <= '0;
    end else if (burst_done && !b_fire) begin
      burst_cnt <= burst_cnt + 1'b1;
    end else if (b_fire && !burst_done) begin
      burst_cnt <= burst_cnt - 1'b1;
    end
  end

  a_burst_cnt_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    burst_cnt <= bridge_pkg::BCNT_WIDTH'(bridge_pkg::BID_FIFO_DEPTH));

endmodule

`default_nettype wire

//--- cmd_arbiter.sv
/*
 * Round-robin merge of the read and write command queues
 * onto the single target command port.
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_rd_valid,
  output logic                                 o_rd_accept,
  input  logic [bridge_pkg::ID_WIDTH-1:0]      i_rd_id,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_rd_addr,
  input  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] i_rd_len,
  input  logic                                 i_wr_valid,
  output logic                                 o_wr_accept,
  input  logic [bridge_pkg::ID_WIDTH-1:0]      i_wr_id,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_wr_addr,
  input  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] i_wr_len,
  output logic                                 o_cmd_valid,
  input  logic                                 i_cmd_accept,
  output bridge_pkg::bus_cmd_e                 o_cmd,
  output logic [bridge_pkg::ID_WIDTH-1:0]      o_cmd_id,
  output logic [bridge_pkg::ADDR_WIDTH-1:0]    o_cmd_addr,
  output logic [bridge_pkg::CMD_LEN_WIDTH-1:0] o_cmd_len
);
  bridge_pkg::arb_owner_e last_owner;
  logic                   grant_wr;
  logic                   cmd_fire;

  // on a tie the queue that did not win last time goes first.
  assign grant_wr = i_wr_valid && (!i_rd_valid || (last_owner == bridge_pkg::RD));
  assign cmd_fire = o_cmd_valid && i_cmd_accept;

  assign o_cmd_valid = i_rd_valid || i_wr_valid;
  assign o_rd_accept = i_cmd_accept && i_rd_valid && !grant_wr;
  assign o_wr_accept = i_cmd_accept && grant_wr;

  always_comb begin
    if (grant_wr) begin
      o_cmd      = bridge_pkg::WRITE;
      o_cmd_id   = i_wr_id;
      o_cmd_addr = i_wr_addr;
      o_cmd_len  = i_wr_len;
    end else begin
      o_cmd      = bridge_pkg::READ;
      o_cmd_id   = i_rd_id;
      o_cmd_addr = i_rd_addr;
      o_cmd_len  = i_rd_len;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_owner <= bridge_pkg::WR;  // reads win the first tie.
    end else if (cmd_fire) begin
      last_owner <= grant_wr ? bridge_pkg::WR : bridge_pkg::RD;
    end
  end

  a_one_accept: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_rd_accept && o_wr_accept));

endmodule

`default_nettype wire

//--- mem_target.sv
/*
 * Bus target on a word memory: one command at a time,
 * byte-enabled write bursts and registered read beats.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_target (
  input  logic                                 i_clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_cmd_valid,
  output logic                                 o_cmd_accept,
  input  bridge_pkg::bus_cmd_e                 i_cmd,
  input  logic [bridge_pkg::ID_WIDTH-1:0]      i_cmd_id,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_cmd_addr,
  input  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] i_cmd_len,
  input  logic                                 i_data_valid,
  output logic                                 o_data_accept,
  input  logic [bridge_pkg::DATA_WIDTH-1:0]    i_data,
  input  logic [bridge_pkg::STRB_WIDTH-1:0]    i_data_byteen,
  input  logic                                 i_data_last,
  output logic                                 o_resp_valid,
  input  logic                                 i_resp_accept,
  output logic [bridge_pkg::ID_WIDTH-1:0]      o_resp_id,
  output logic [bridge_pkg::DATA_WIDTH-1:0]    o_resp_data,
  output logic                                 o_resp_last,
  output logic                                 o_resp_error
);
  bridge_pkg::tgt_state_e                 state;
  logic [bridge_pkg::DATA_WIDTH-1:0]      mem [bridge_pkg::MEM_WORDS];
  logic [bridge_pkg::WORD_ADDR_WIDTH-1:0] word_addr;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0]   beats_left;
  logic [bridge_pkg::WORD_ADDR_WIDTH-1:0] rd_addr;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0]   rd_len;
  logic                                   cmd_take;
  logic                                   rd_start;
  logic                                   resp_done;
  logic                                   beat_load;
  logic                                   wr_beat;
  logic                                   rd_in_range;
  logic                                   wr_in_range;

  assign o_cmd_accept  = (state == bridge_pkg::IDLE);
  assign o_data_accept = (state == bridge_pkg::WRITE_BURST);
  assign cmd_take      = i_cmd_valid && o_cmd_accept;
  assign rd_start      = cmd_take && (i_cmd == bridge_pkg::READ);
  assign resp_done     = o_resp_valid && i_resp_accept;
  assign wr_beat       = i_data_valid && o_data_accept;

  // next read beat loads on the command or after the previous beat leaves.
  assign beat_load   = rd_start || (resp_done && !o_resp_last);
  assign rd_addr     = rd_start ? i_cmd_addr[bridge_pkg::ADDR_WIDTH-1:2] : word_addr;
  assign rd_len      = rd_start ? i_cmd_len : beats_left;
  assign rd_in_range = (rd_addr < bridge_pkg::WORD_ADDR_WIDTH'(bridge_pkg::MEM_WORDS));
  assign wr_in_range = (word_addr < bridge_pkg::WORD_ADDR_WIDTH'(bridge_pkg::MEM_WORDS));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= bridge_pkg::IDLE;
      word_addr    <= '0;
      beats_left   <= '0;
      o_resp_valid <= 1'b0;
      o_resp_last  <= 1'b0;
      o_resp_error <= 1'b0;
    end else begin
      case (state)
        bridge_pkg::IDLE:
          if (cmd_take) begin
            state <= rd_start ? bridge_pkg::READ_BURST : bridge_pkg::WRITE_BURST;
          end
        bridge_pkg::READ_BURST:
          if (resp_done && o_resp_last) state <= bridge_pkg::IDLE;
        bridge_pkg::WRITE_BURST:
          if (wr_beat && (beats_left == 1)) state <= bridge_pkg::IDLE;
        default: state <= bridge_pkg::IDLE;
      endcase

      if (beat_load) begin
        word_addr    <= rd_addr + 1'b1;
        beats_left   <= rd_len - 1'b1;
        o_resp_valid <= 1'b1;
        o_resp_last  <= (rd_len == 1);
        o_resp_error <= !rd_in_range;  // beyond memory.
      end else if (cmd_take) begin  // write command.
        word_addr  <= i_cmd_addr[bridge_pkg::ADDR_WIDTH-1:2];
        beats_left <= i_cmd_len;
      end else if (wr_beat) begin
        word_addr  <= word_addr + 1'b1;
        beats_left <= beats_left - 1'b1;
      end

      if (resp_done && !beat_load) o_resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_take) o_resp_id <= i_cmd_id;
    if (beat_load) begin
      o_resp_data <= rd_in_range ? mem[rd_addr[bridge_pkg::MEM_ADDR_WIDTH-1:0]] : '0;
    end
    if (wr_beat && wr_in_range) begin  // out of range writes are dropped.
      for (int b = 0; b < bridge_pkg::STRB_WIDTH; b++) begin
        if (i_data_byteen[b]) begin
          mem[word_addr[bridge_pkg::MEM_ADDR_WIDTH-1:0]][8*b +: 8] <= i_data[8*b +: 8];
        end
      end
    end
  end

  // wlast from the AXI side must line up with the command beat count.
  a_last_on_final: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    wr_beat |-> (i_data_last == (beats_left == 1)));

endmodule

`default_nettype wire

//--- axi_bridge_top.sv
/*
 * Bridge top: read and write paths, command arbiter and memory target.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_bridge_top (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_arvalid,
  output logic                              o_arready,
  input  logic [bridge_pkg::ID_WIDTH-1:0]   i_arid,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0] i_araddr,
  input  logic [bridge_pkg::LEN_WIDTH-1:0]  i_arlen,
  output logic                              o_rvalid,
  input  logic                              i_rready,
  output logic [bridge_pkg::ID_WIDTH-1:0]   o_rid,
  output logic [bridge_pkg::DATA_WIDTH-1:0] o_rdata,
  output bridge_pkg::axi_resp_e             o_rresp,
  output logic                              o_rlast,
  input  logic                              i_awvalid,
  output logic                              o_awready,
  input  logic [bridge_pkg::ID_WIDTH-1:0]   i_awid,
  input  logic [bridge_pkg::ADDR_WIDTH-1:0] i_awaddr,
  input  logic [bridge_pkg::LEN_WIDTH-1:0]  i_awlen,
  input  logic                              i_wvalid,
  output logic                              o_wready,
  input  logic [bridge_pkg::DATA_WIDTH-1:0] i_wdata,
  input  logic [bridge_pkg::STRB_WIDTH-1:0] i_wstrb,
  input  logic                              i_wlast,
  output logic                              o_bvalid,
  input  logic                              i_bready,
  output logic [bridge_pkg::ID_WIDTH-1:0]   o_bid,
  output bridge_pkg::axi_resp_e             o_bresp
);
  // read queue to arbiter.
  logic                                 rd_valid;
  logic                                 rd_accept;
  logic [bridge_pkg::ID_WIDTH-1:0]      rd_id;
  logic [bridge_pkg::ADDR_WIDTH-1:0]    rd_addr;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] rd_len;
  // write queue to arbiter.
  logic                                 wr_valid;
  logic                                 wr_accept;
  logic [bridge_pkg::ID_WIDTH-1:0]      wr_id;
  logic [bridge_pkg::ADDR_WIDTH-1:0]    wr_addr;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] wr_len;
  // arbiter to target.
  logic                                 cmd_valid;
  logic                                 cmd_accept;
  bridge_pkg::bus_cmd_e                 cmd;
  logic [bridge_pkg::ID_WIDTH-1:0]      cmd_id;
  logic [bridge_pkg::ADDR_WIDTH-1:0]    cmd_addr;
  logic [bridge_pkg::CMD_LEN_WIDTH-1:0] cmd_len;
  // write data and read responses.
  logic                                 data_valid;
  logic                                 data_accept;
  logic [bridge_pkg::DATA_WIDTH-1:0]    data;
  logic [bridge_pkg::STRB_WIDTH-1:0]    data_byteen;
  logic                                 data_last;
  logic                                 resp_valid;
  logic                                 resp_accept;
  logic [bridge_pkg::ID_WIDTH-1:0]      resp_id;
  logic [bridge_pkg::DATA_WIDTH-1:0]    resp_data;
  logic                                 resp_last;
  logic                                 resp_error;

  read_cmd_path u_read_path (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_arvalid (i_arvalid), .o_arready (o_arready), .i_arid (i_arid),
    .i_araddr (i_araddr), .i_arlen (i_arlen),
    .o_rvalid (o_rvalid), .i_rready (i_rready), .o_rid (o_rid),
    .o_rdata (o_rdata), .o_rresp (o_rresp), .o_rlast (o_rlast),
    .o_cmd_valid (rd_valid), .i_cmd_accept (rd_accept), .o_cmd_id (rd_id),
    .o_cmd_addr (rd_addr), .o_cmd_len (rd_len),
    .i_resp_valid (resp_valid), .o_resp_accept (resp_accept), .i_resp_id (resp_id),
    .i_resp_data (resp_data), .i_resp_last (resp_last), .i_resp_error (resp_error)
  );

  write_cmd_path u_write_path (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awid (i_awid),
    .i_awaddr (i_awaddr), .i_awlen (i_awlen),
    .i_wvalid (i_wvalid), .o_wready (o_wready), .i_wdata (i_wdata),
    .i_wstrb (i_wstrb), .i_wlast (i_wlast),
    .o_bvalid (o_bvalid), .i_bready (i_bready), .o_bid (o_bid), .o_bresp (o_bresp),
    .o_cmd_valid (wr_valid), .i_cmd_accept (wr_accept), .o_cmd_id (wr_id),
    .o_cmd_addr (wr_addr), .o_cmd_len (wr_len),
    .o_data_valid (data_valid), .i_data_accept (data_accept), .o_data (data),
    .o_data_byteen (data_byteen), .o_data_last (data_last)
  );

  cmd_arbiter u_arbiter (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_rd_valid (rd_valid), .o_rd_accept (rd_accept), .i_rd_id (rd_id),
    .i_rd_addr (rd_addr), .i_rd_len (rd_len),
    .i_wr_valid (wr_valid), .o_wr_accept (wr_accept), .i_wr_id (wr_id),
    .i_wr_addr (wr_addr), .i_wr_len (wr_len),
    .o_cmd_valid (cmd_valid), .i_cmd_accept (cmd_accept), .o_cmd (cmd),
    .o_cmd_id (cmd_id), .o_cmd_addr (cmd_addr), .o_cmd_len (cmd_len)
  );

  mem_target u_target (
    .i_clk (i_clk), .i_rst_n (i_rst_n),
    .i_cmd_valid (cmd_valid), .o_cmd_accept (cmd_accept), .i_cmd (cmd),
    .i_cmd_id (cmd_id), .i_cmd_addr (cmd_addr), .i_cmd_len (cmd_len),
    .i_data_valid (data_valid), .o_data_accept (data_accept), .i_data (data),
    .i_data_byteen (data_byteen), .i_data_last (data_last),
    .o_resp_valid (resp_valid), .i_resp_accept (resp_accept), .o_resp_id (resp_id),
    .o_resp_data (resp_data), .o_resp_last (resp_last), .o_resp_error (resp_error)
  );

endmodule

`default_nettype wire

//--- tb_axi_bridge.sv
/*
 * Directed testbench for the AXI bridge: reference memory model,
 * AXI channel tasks, typed compare tasks and a watchdog.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_bridge;

  localparam int CLK_PERIOD  = 40;
  localparam int TOTAL_BEATS = 119;  // every R and W beat issued below.

  logic                                 i_clk;
  logic                                 i_rst_n;
  logic                                 i_arvalid;
  logic                                 o_arready;
  logic [bridge_pkg::ID_WIDTH-1:0]      i_arid;
  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_araddr;
  logic [bridge_pkg::LEN_WIDTH-1:0]     i_arlen;
  logic                                 o_rvalid;
  logic                                 i_rready;
  logic [bridge_pkg::ID_WIDTH-1:0]      o_rid;
  logic [bridge_pkg::DATA_WIDTH-1:0]    o_rdata;
  bridge_pkg::axi_resp_e                o_rresp;
  logic                                 o_rlast;
  logic                                 i_awvalid;
  logic                                 o_awready;
  logic [bridge_pkg::ID_WIDTH-1:0]      i_awid;
  logic [bridge_pkg::ADDR_WIDTH-1:0]    i_awaddr;
  logic [bridge_pkg::LEN_WIDTH-1:0]     i_awlen;
  logic                                 i_wvalid;
  logic                                 o_wready;
  logic [bridge_pkg::DATA_WIDTH-1:0]    i_wdata;
  logic [bridge_pkg::STRB_WIDTH-1:0]    i_wstrb;
  logic                                 i_wlast;
  logic                                 o_bvalid;
  logic                                 i_bready;
  logic [bridge_pkg::ID_WIDTH-1:0]      o_bid;
  bridge_pkg::axi_resp_e                o_bresp;

  logic [bridge_pkg::DATA_WIDTH-1:0] ref_mem [bridge_pkg::MEM_WORDS];  // expected memory.
  int                                error_count;
  logic                              stall_mode;  // random rready and bready gaps.

  axi_bridge_top i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(TOTAL_BEATS * 40 * CLK_PERIOD);
    $display("watchdog timeout at %0t, the tests did not complete", $time);
    $display("errors: %0d", error_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check_data(input string name, input logic [bridge_pkg::DATA_WIDTH-1:0] got,
                            input logic [bridge_pkg::DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [bridge_pkg::ID_WIDTH-1:0] got,
                          input logic [bridge_pkg::ID_WIDTH-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input bridge_pkg::axi_resp_e got,
                            input bridge_pkg::axi_resp_e exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR @%0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // byte lanes with a strobe take the new data.
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  function automatic logic [31:0] expect_word(input int idx);
    return (idx < bridge_pkg::MEM_WORDS) ? ref_mem[idx] : '0;  // out of range reads zero.
  endfunction

  task automatic send_aw(input logic [3:0] id, input logic [15:0] addr, input int beats);
    @(negedge i_clk);
    i_awvalid = 1'b1;
    i_awid    = id;
    i_awaddr  = addr;
    i_awlen   = bridge_pkg::LEN_WIDTH'(beats - 1);
    #1;
    while (!o_awready) begin
      @(negedge i_clk);
      #1;
    end
    @(negedge i_clk);
    i_awvalid = 1'b0;
  endtask

  // a zero strobe argument asks for random strobes.
  task automatic send_w(input logic [15:0] addr, input int beats, input logic [3:0] strb);
    int idx;
    for (int b = 0; b < beats; b++) begin
      @(negedge i_clk);
      i_wvalid = 1'b1;
      i_wdata  = $urandom;
      i_wstrb  = (strb == 4'h0) ? bridge_pkg::STRB_WIDTH'($urandom) : strb;
      i_wlast  = (b == beats - 1);
      #1;
      while (!o_wready) begin
        @(negedge i_clk);
        #1;
      end
      idx = int'(addr >> 2) + b;
      if (idx < bridge_pkg::MEM_WORDS) begin
        ref_mem[idx] = merge_bytes(ref_mem[idx], i_wdata, i_wstrb);
      end
    end
    @(negedge i_clk);
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
  endtask

  task automatic wait_b(input logic [3:0] id);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge i_clk);
      i_bready = stall_mode ? ($urandom_range(3) != 0) : 1'b1;
      #1;
      if (o_bvalid && i_bready) begin
        check_id("bid", o_bid, id);
        check_resp("bresp", o_bresp, bridge_pkg::OKAY);
        done = 1'b1;
      end
    end
    @(negedge i_clk);
    i_bready = 1'b0;
  endtask

  task automatic axi_write(input logic [3:0] id, input logic [15:0] addr, input int beats,
                           input logic [3:0] strb);
    fork
      send_aw(id, addr, beats);
      send_w(addr, beats, strb);
    join
    wait_b(id);
  endtask

  task automatic axi_read(input logic [3:0] id, input logic [15:0] addr, input int beats);
    int          n;
    int          idx;
    logic        held_v;
    logic [31:0] held;
    n      = 0;
    held_v = 1'b0;
    @(negedge i_clk);
    i_arvalid = 1'b1;
    i_arid    = id;
    i_araddr  = addr;
    i_arlen   = bridge_pkg::LEN_WIDTH'(beats - 1);
    #1;
    while (!o_arready) begin
      @(negedge i_clk);
      #1;
    end
    @(negedge i_clk);
    i_arvalid = 1'b0;
    while (n < beats) begin
      i_rready = stall_mode ? ($urandom_range(3) != 0) : 1'b1;
      #1;
      if (held_v) begin  // a stalled beat must not move.
        if (!o_rvalid) begin
          error_count++;
          $display("ERROR @%0t: rvalid dropped while rready was low", $time);
        end
        check_data("rdata while stalled", o_rdata, held);
      end
      held_v = 1'b0;
      if (o_rvalid && i_rready) begin
        idx = int'(addr >> 2) + n;
        check_id("rid", o_rid, id);
        check_data("rdata", o_rdata, expect_word(idx));
        check_resp("rresp", o_rresp,
                   (idx < bridge_pkg::MEM_WORDS) ? bridge_pkg::OKAY : bridge_pkg::SLVERR);
        check_flag("rlast", o_rlast, n == beats - 1);
        n++;
      end else if (o_rvalid) begin
        held_v = 1'b1;
        held   = o_rdata;
      end
      @(negedge i_clk);
    end
    i_rready = 1'b0;
    #1;
    if (o_rvalid) begin
      error_count++;
      $display("ERROR @%0t: an extra R beat followed the last one", $time);
    end
  endtask

  task automatic apply_reset();
    @(negedge i_clk);
    #1;
    check_flag("wready in reset", o_wready, 1'b0);
    check_flag("rvalid in reset", o_rvalid, 1'b0);
    check_flag("bvalid in reset", o_bvalid, 1'b0);
    @(negedge i_clk);
    i_rst_n = 1'b1;
  endtask

  task automatic test_reset_and_strobe();
    @(negedge i_clk);
    #1;
    check_flag("wready idle", o_wready, 1'b0);
    check_flag("rvalid idle", o_rvalid, 1'b0);
    check_flag("bvalid idle", o_bvalid, 1'b0);
    check_flag("arready idle", o_arready, 1'b1);  // empty queues take requests.
    check_flag("awready idle", o_awready, 1'b1);
    axi_write(4'h1, 16'h0004, 1, 4'hf);
    axi_write(4'h2, 16'h0004, 1, 4'b0101);
    axi_read(4'h3, 16'h0004, 1);
  endtask

  task automatic test_bursts();
    axi_write(4'h1, 16'h0010, 1, 4'hf);
    axi_write(4'h2, 16'h0100, 8, 4'hf);
    axi_write(4'h3, 16'h0200, 16, 4'hf);
    axi_read(4'h4, 16'h0010, 1);
    axi_read(4'h5, 16'h0100, 8);
    axi_read(4'h6, 16'h0200, 16);
  endtask

  // 0x0404 aliases words 1 to 4 if the top address bits were lost.
  task automatic test_out_of_range();
    axi_read(4'h7, 16'h0400, 4);
    axi_write(4'h8, 16'h0404, 4, 4'hf);
    axi_read(4'h9, 16'h0004, 1);
    axi_read(4'ha, 16'h0010, 1);
  endtask

  task automatic test_stalls();
    stall_mode = 1'b1;
    axi_write(4'hb, 16'h0100, 8, 4'h0);
    axi_read(4'hc, 16'h0100, 8);
    axi_read(4'hd, 16'h0200, 16);
    stall_mode = 1'b0;
  endtask

  task automatic test_concurrent();
    fork
      begin
        send_aw(4'h1, 16'h0300, 4);
        send_aw(4'h2, 16'h0340, 4);
        send_aw(4'h3, 16'h0380, 4);
      end
      begin
        send_w(16'h0300, 4, 4'hf);
        send_w(16'h0340, 4, 4'hf);
        send_w(16'h0380, 4, 4'hf);
      end
      begin  // responses must follow AW order.
        wait_b(4'h1);
        wait_b(4'h2);
        wait_b(4'h3);
      end
      axi_read(4'h4, 16'h0200, 8);
    join
    axi_read(4'h5, 16'h0340, 4);
  endtask

  initial begin
    void'($urandom(32'h6171_75a9));
    error_count = 0;
    stall_mode  = 1'b0;
    i_rst_n     = 1'b0;
    i_arvalid   = 1'b0;
    i_arid      = '0;
    i_araddr    = '0;
    i_arlen     = '0;
    i_rready    = 1'b0;
    i_awvalid   = 1'b0;
    i_awid      = '0;
    i_awaddr    = '0;
    i_awlen     = '0;
    i_wvalid    = 1'b0;
    i_wdata     = '0;
    i_wstrb     = '0;
    i_wlast     = 1'b0;
    i_bready    = 1'b0;
    apply_reset();
    test_reset_and_strobe();
    test_bursts();
    test_out_of_range();
    test_stalls();
    test_concurrent();
    @(negedge i_clk);
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
bridge_pkg.sv
sync_fifo.sv
read_cmd_path.sv
write_cmd_path.sv
cmd_arbiter.sv
mem_target.sv
axi_bridge_top.sv
tb_axi_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it, and check the log.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tb_axi_bridge -o tb_axi_bridge &&
  ./obj_dir/tb_axi_bridge > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null &&
  echo "run_sim: simulation passed" ||
  { echo "run_sim: simulation failed"; exit 1; }
